// File: hdl/lsu_op_pkg.sv
// operation, element format and sequencer state types.
package lsu_op_pkg;

    // ====================
    // command encodings
    // ====================
    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } lsu_op_e;

    typedef enum logic [1:0] {
        fmt_b = 2'd0, // 1 byte.
        fmt_h = 2'd1, // 2 bytes.
        fmt_w = 2'd2, // 4 bytes.
        fmt_d = 2'd3  // 8 bytes and legal with flen 64 only.
    } lsu_fmt_e;

    typedef enum logic [1:0] {
        st_idle, st_issue, st_wait, st_done
    } seq_state_e;

endpackage

// File: hdl/lsu_bus_pkg.sv
// memory port widths and the beat size type.
package lsu_bus_pkg;

    // ====================
    // memory port
    // ====================
    localparam int BUS_BYTES = 4;
    localparam int ADDR_W    = 32;

    // size of one access on the port.
    typedef enum logic [1:0] {
        bs_byte = 2'd0,
        bs_half = 2'd1,
        bs_word = 2'd2
    } beat_size_e;

endpackage

// File: hdl/lsu_split_decode.sv
// split decoder giving size, next offset and flags for one beat.
`timescale 1ns/1ps

module lsu_split_decode #(
    parameter int flen = 64
) (
    input  logic [2:0]             base,
    input  logic [2:0]             offset,
    input  logic                   store,
    input  logic                   load,
    input  lsu_op_pkg::lsu_fmt_e   fmt,
    output lsu_bus_pkg::beat_size_e size,
    output logic [2:0]             offset_nx,
    output logic                   last,
    output logic                   multi,
    output logic                   una,
    output logic                   illegal
);
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;

    logic [3:0]  esz;     // element size in bytes.
    logic [2:0]  cur;     // low bits of the current byte address.
    logic [3:0]  room;    // bytes left in the current word.
    logic [3:0]  rem;     // bytes left in the element.
    logic [3:0]  covered;
    logic [3:0]  end_nx;
    beat_size_e  piece;
    logic        active;

    always_comb begin
        case (fmt)
            fmt_b:   esz = 4'd1;
            fmt_h:   esz = 4'd2;
            fmt_w:   esz = 4'd4;
            default: esz = 4'd8;
        endcase
        active = load | store;
        cur    = base + offset;
        room   = 4'd4 - {2'b00, cur[1:0]};
        rem    = esz - {1'b0, offset};

        // largest aligned store piece that stays inside the element.
        if (cur[1:0] == 2'd0 && rem >= 4'd4) begin
            piece = bs_word;
        end else if (!cur[0] && rem >= 4'd2) begin
            piece = bs_half;
        end else begin
            piece = bs_byte;
        end

        if (load) begin
            covered = (room < rem) ? room : rem; // whole word is read.
            size    = bs_word;
        end else if (store) begin
            case (piece)
                bs_word: covered = 4'd4;
                bs_half: covered = 4'd2;
                default: covered = 4'd1;
            endcase
            size = piece;
        end else begin
            covered = 4'd0;
            size    = bs_byte;
        end

        end_nx    = {1'b0, offset} + covered;
        offset_nx = end_nx[2:0]; // wraps to 0 at the end of a double.
        last      = active & (end_nx == esz);
        una       = active & ((base & 3'(esz - 4'd1)) != 3'd0);
        multi     = (load & (({2'b00, base[1:0]} + esz) > 4'd4))
                  | (store & ((fmt == fmt_d) | una));
        illegal   = active & (fmt == fmt_d) & (flen != 64);
    end

endmodule

// File: hdl/lsu_seq_ctrl.sv
// sequencer FSM issuing memory beats and ending each access.
`timescale 1ns/1ps

module lsu_seq_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  lsu_op_pkg::lsu_op_e  op,
    input  lsu_op_pkg::lsu_fmt_e fmt,
    input  logic                 last,
    input  logic                 illegal,
    input  logic                 mem_ack,
    input  logic [2:0]           offset_nx,
    output logic                 busy,
    output logic                 done,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic                 cmd_load,
    output logic                 beat_adv,
    output logic [2:0]           offset,
    output lsu_op_pkg::lsu_fmt_e cur_fmt,
    output logic                 dec_load,
    output logic                 dec_store
);
    import lsu_op_pkg::*;

    seq_state_e state;
    lsu_op_e    op_q;

    assign busy      = (state != st_idle);
    assign done      = (state == st_done);
    assign cmd_load  = start & ~busy; // start while busy is dropped.
    assign mem_req   = (state == st_issue) & ~illegal;
    assign beat_adv  = mem_ack & (mem_req | (state == st_wait));
    assign mem_we    = (op_q == op_store);
    assign dec_load  = busy & (op_q == op_load);
    assign dec_store = busy & (op_q == op_store);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            op_q    <= op_load;
            cur_fmt <= fmt_b;
            offset  <= 3'd0;
        end else begin
            if (cmd_load) begin
                op_q    <= op;
                cur_fmt <= fmt;
                offset  <= 3'd0;
            end
            if (beat_adv) begin
                offset <= offset_nx;
            end
            case (state)
                st_idle:  if (start) state <= st_issue;
                st_issue: begin
                    if (illegal) begin
                        state <= st_done; // no beat for an illegal format.
                    end else if (beat_adv) begin
                        state <= last ? st_done : st_issue;
                    end else begin
                        state <= st_wait;
                    end
                end
                st_wait:  if (beat_adv) state <= last ? st_done : st_issue;
                default:  state <= st_idle;
            endcase
        end
    end

endmodule

// File: hdl/lsu_addr_gen.sv
// element address latch and word-aligned beat address.
`timescale 1ns/1ps

module lsu_addr_gen (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_load,
    input  logic                           beat_adv,
    input  logic [lsu_bus_pkg::ADDR_W-1:0] addr,
    input  logic [2:0]                     offset_nx,
    output logic [lsu_bus_pkg::ADDR_W-1:0] mem_addr,
    output logic [2:0]                     base
);
    import lsu_bus_pkg::*;

    logic [ADDR_W-1:0] elem_addr;
    logic [ADDR_W-1:0] beat_addr; // byte address of the current beat.

    always_ff @(posedge clk) begin
        if (cmd_load) elem_addr <= addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_addr <= '0;
        end else if (cmd_load) begin
            beat_addr <= addr;
        end else if (beat_adv) begin
            beat_addr <= elem_addr + ADDR_W'(offset_nx);
        end
    end

    assign mem_addr = {beat_addr[ADDR_W-1:2], 2'b00};
    assign base     = elem_addr[2:0];

endmodule

// File: hdl/lsu_load_merge.sv
// load merger collecting beat bytes into the element result.
`timescale 1ns/1ps

module lsu_load_merge #(
    parameter int flen = 64
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    cmd_load,
    input  logic                                    load,
    input  logic                                    mem_ack,
    input  logic [8*lsu_bus_pkg::BUS_BYTES-1:0]     mem_rdata,
    input  logic [2:0]                              base,
    input  logic [2:0]                              offset,
    input  logic [2:0]                              offset_nx,
    input  lsu_op_pkg::lsu_fmt_e                    fmt,
    output logic [flen-1:0]                         load_data
);
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;

    localparam int NB = flen / 8;

    logic [flen-1:0]    elem_q;
    logic [flen-1:0]    fmt_mask;
    logic [2:0]         cur;
    logic [2:0]         covered;
    logic [2:0]         lane_idx [BUS_BYTES];
    logic [BUS_BYTES-1:0] lane_hit;

    always_comb begin
        cur     = base + offset;
        covered = offset_nx - offset; // taken mod 8 so a double's tail comes out right.
        for (int j = 0; j < BUS_BYTES; j++) begin
            lane_idx[j] = offset + 3'(j) - {1'b0, cur[1:0]};
            lane_hit[j] = (3'(j) >= {1'b0, cur[1:0]})
                        && ((3'(j) - {1'b0, cur[1:0]}) < covered)
                        && (int'(lane_idx[j]) < NB);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || cmd_load) begin
            elem_q <= '0;
        end else if (mem_ack && load) begin
            for (int j = 0; j < BUS_BYTES; j++) begin
                if (lane_hit[j]) elem_q[lane_idx[j]*8 +: 8] <= mem_rdata[j*8 +: 8];
            end
        end
    end

    // zero-extend narrow formats.
    always_comb begin
        case (fmt)
            fmt_b:   fmt_mask = flen'(64'h0000_0000_0000_00ff);
            fmt_h:   fmt_mask = flen'(64'h0000_0000_0000_ffff);
            fmt_w:   fmt_mask = flen'(64'h0000_0000_ffff_ffff);
            default: fmt_mask = '1;
        endcase
    end

    assign load_data = elem_q & fmt_mask;

endmodule

// File: hdl/lsu_store_align.sv
// store aligner rotating element bytes onto the write lanes.
`timescale 1ns/1ps

module lsu_store_align #(
    parameter int flen = 64
) (
    input  logic                                clk,
    input  logic                                cmd_load,
    input  logic [flen-1:0]                     store_data,
    input  logic [2:0]                          base,
    input  logic [2:0]                          offset,
    input  lsu_bus_pkg::beat_size_e             size,
    output logic [8*lsu_bus_pkg::BUS_BYTES-1:0] mem_wdata,
    output logic [lsu_bus_pkg::BUS_BYTES-1:0]   mem_be
);
    import lsu_bus_pkg::*;

    localparam int WW = 8 * BUS_BYTES;

    logic [flen-1:0] data_q;
    logic [flen-1:0] shifted;
    logic [2*WW-1:0] dbl;
    logic [1:0]      lane; // lane of the current byte.

    always_ff @(posedge clk) begin
        if (cmd_load) data_q <= store_data;
    end

    always_comb begin
        lane    = 2'(base + offset);
        shifted = data_q >> {offset, 3'b000}; // byte at offset goes to bit 0.
        dbl     = {shifted[WW-1:0], shifted[WW-1:0]};
        mem_wdata = dbl[WW - 8*lane +: WW]; // rotate left by lane bytes.
        case (size)
            bs_byte: mem_be = 4'b0001 << lane;
            bs_half: mem_be = 4'b0011 << lane;
            default: mem_be = 4'b1111;
        endcase
    end

endmodule

// File: hdl/fp_lsu_top.sv
// top level of the misaligned fp load/store unit.
`timescale 1ns/1ps

module fp_lsu_top #(
    parameter int flen = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  lsu_op_pkg::lsu_op_e                 op,
    input  lsu_op_pkg::lsu_fmt_e                fmt,
    input  logic [lsu_bus_pkg::ADDR_W-1:0]      addr,
    input  logic [flen-1:0]                     store_data,
    output logic                                busy,
    output logic                                done,
    output logic [flen-1:0]                     load_data,
    output logic                                una,
    output logic                                multi,
    output logic                                illegal,
    output logic                                mem_req,
    output logic                                mem_we,
    output logic [lsu_bus_pkg::ADDR_W-1:0]      mem_addr,
    output logic [lsu_bus_pkg::BUS_BYTES-1:0]   mem_be,
    output logic [8*lsu_bus_pkg::BUS_BYTES-1:0] mem_wdata,
    input  logic                                mem_ack,
    input  logic [8*lsu_bus_pkg::BUS_BYTES-1:0] mem_rdata
);
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;

    logic       last, cmd_load, beat_adv, dec_load, dec_store;
    logic [2:0] offset, offset_nx, base;
    lsu_fmt_e   cur_fmt;
    beat_size_e size;

    lsu_seq_ctrl i_seq (
        .clk, .rst, .start, .op, .fmt, .last, .illegal, .mem_ack, .offset_nx,
        .busy, .done, .mem_req, .mem_we, .cmd_load, .beat_adv, .offset,
        .cur_fmt, .dec_load, .dec_store
    );

    lsu_split_decode #(.flen(flen)) i_dec (
        .base, .offset, .store(dec_store), .load(dec_load), .fmt(cur_fmt),
        .size, .offset_nx, .last, .multi, .una, .illegal
    );

    lsu_addr_gen i_addr (
        .clk, .rst, .cmd_load, .beat_adv, .addr, .offset_nx, .mem_addr, .base
    );

    lsu_load_merge #(.flen(flen)) i_merge (
        .clk, .rst, .cmd_load, .load(dec_load), .mem_ack, .mem_rdata,
        .base, .offset, .offset_nx, .fmt(cur_fmt), .load_data
    );

    lsu_store_align #(.flen(flen)) i_align (
        .clk, .cmd_load, .store_data, .base, .offset, .size, .mem_wdata, .mem_be
    );

endmodule

// File: sim/fp_lsu_assertions.sv
// bound concurrent checks on the memory port and the sequencer.
`timescale 1ns/1ps

module fp_lsu_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic                           mem_req,
    input logic                           mem_ack,
    input logic                           done,
    input logic [lsu_bus_pkg::ADDR_W-1:0] mem_addr
);
    logic pending; // beat requested and not yet acked.

    always_ff @(posedge clk) begin
        if (rst || mem_ack) begin
            pending <= 1'b0;
        end else if (mem_req) begin
            pending <= 1'b1;
        end
    end

    // ====================
    // memory port
    // ====================
    a_one_beat: assert property (@(posedge clk) disable iff (rst) mem_req |-> !pending)
        else $error("mem_req raised before the previous beat was acked");
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (pending && !mem_ack) |-> $stable(mem_addr))
        else $error("mem_addr changed while a beat was waiting for its ack");
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

endmodule

// File: sim/tb_fp_lsu.sv
// testbench with clock, reset, memory model, stimulus, reference functions and checker.
`timescale 1ns/1ps

module tb_fp_lsu;
    import lsu_op_pkg::*;

    localparam int MAX_CYCLES = 200 * 40;

    logic         clk, rst, start, busy, done, una, multi, illegal;
    lsu_op_e      op;
    lsu_fmt_e     fmt;
    logic [31:0]  addr, mem_addr, mem_wdata, mem_rdata;
    logic [63:0]  store_data, load_data, exp_data;
    logic         mem_req, mem_we, mem_ack, exp_una, exp_multi, exp_store;
    logic [3:0]   mem_be;
    logic [511:0] mem_model, ref_mem; // byte i sits at [8*i +: 8].
    int           req_count, exp_beats, n_issued, n_checked, cycles, seed;

    fp_lsu_top #(.flen(64)) i_dut (
        .clk, .rst, .start, .op, .fmt, .addr, .store_data, .busy, .done, .load_data,
        .una, .multi, .illegal, .mem_req, .mem_we, .mem_addr, .mem_be, .mem_wdata,
        .mem_ack, .mem_rdata
    );

    bind fp_lsu_top fp_lsu_assertions i_assert (.clk, .rst, .mem_req, .mem_ack, .done, .mem_addr);

    // ====================
    // reference model
    // ====================
    function automatic int fmt_bytes(input lsu_fmt_e f);
        case (f)
            fmt_b:   return 1;
            fmt_h:   return 2;
            fmt_w:   return 4;
            default: return 8;
        endcase
    endfunction

    // {una, multi, beat count}.
    function automatic logic [5:0] split_ref(input int a, input int n, input bit is_store);
        int cur, stop, beats, piece;
        beats = (a % 4 + n + 3) / 4; // loads read whole words.
        if (is_store) begin
            beats = 0;
            cur   = a;
            stop  = a + n;
            while (cur < stop) begin
                if (cur % 4 == 0 && stop - cur >= 4) piece = 4;
                else if (cur % 2 == 0 && stop - cur >= 2) piece = 2;
                else piece = 1;
                cur   = cur + piece;
                beats = beats + 1;
            end
        end
        return {(a % n) != 0, beats > 1, 4'(beats)};
    endfunction

    function automatic logic [63:0] load_ref(input logic [511:0] m, input int a, input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r[8*i +: 8] = m[8*(a+i) +: 8];
        return r;
    endfunction

    function automatic logic [511:0] store_ref(input logic [511:0] m, input int a, input int n,
                                               input logic [63:0] d);
        for (int i = 0; i < n; i++) m[8*(a+i) +: 8] = d[8*i +: 8];
        return m;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic run_cmd(input lsu_op_e o, input lsu_fmt_e f, input int a,
                           input logic [63:0] d, input bit dup);
        logic [5:0] fl;
        @(posedge clk);
        #1;
        fl        = split_ref(a, fmt_bytes(f), o == op_store);
        exp_una   = fl[5];
        exp_multi = fl[4];
        exp_beats = fl[3:0];
        exp_store = (o == op_store);
        exp_data  = load_ref(ref_mem, a, fmt_bytes(f));
        if (exp_store) ref_mem = store_ref(ref_mem, a, fmt_bytes(f), d);
        start      = 1'b1;
        op         = o;
        fmt        = f;
        addr       = a;
        store_data = d;
        req_count  = 0;
        n_issued++;
        @(posedge clk);
        #1;
        start      = dup; // a store elsewhere that busy must drop.
        op         = op_store;
        fmt        = fmt_w;
        addr       = (32'(a) & 32'hffff_fffc) ^ 32'h20;
        store_data = '1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        while (done !== 1'b1) @(negedge clk);
    endtask

    // ====================
    // clock, timeout, memory
    // ====================
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the commands did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : mem_proc
        int idx, delay;
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (mem_req === 1'b1) begin
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                if (delay != 0) #1;
                idx = mem_addr[5:0];
                for (int j = 0; j < 4; j++) begin
                    if (mem_we && mem_be[j]) mem_model[8*(idx+j) +: 8] = mem_wdata[8*j +: 8];
                end
                mem_rdata = mem_model[8*idx +: 32];
                mem_ack   = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (mem_req === 1'b1) req_count++;
    end

    // outputs are stable at the falling edge of the done cycle.
    initial begin : compare
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                check(una, exp_una, "una");
                check(multi, exp_multi, "multi");
                check(illegal, 1'b0, "illegal");
                check(req_count, exp_beats, "beat count");
                if (exp_store) begin
                    for (int i = 0; i < 64; i++) begin
                        check(mem_model[8*i +: 8], ref_mem[8*i +: 8], "memory byte");
                    end
                end else begin
                    check(load_data, exp_data, "load data");
                end
                n_checked++;
            end
        end
    end

    initial begin : stimulus
        seed = $urandom(32'h1eb6);
        rst        = 1'b1;
        start      = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        addr       = '0;
        store_data = '0;
        op         = op_load;
        fmt        = fmt_b;
        req_count  = 0;
        n_issued   = 0;
        n_checked  = 0;
        for (int i = 0; i < 64; i++) mem_model[8*i +: 8] = 8'(i * 37 + 11);
        ref_mem = mem_model;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check({busy, mem_req, done}, 3'b000, "state after reset");
        for (int k = 0; k < 4; k++) run_cmd(op_load, lsu_fmt_e'(k), 8, 64'd0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < 8; b++) run_cmd(op_load, lsu_fmt_e'(k), 16 + b, 64'd0, 1'b0);
            for (int b = 0; b < 8; b++) begin
                run_cmd(op_store, lsu_fmt_e'(k), 32 + b, {$urandom, $urandom}, 1'b0);
            end
        end
        // random mix with a second start while busy.
        for (int n = 0; n < 60; n++) begin
            run_cmd(lsu_op_e'($urandom % 2), lsu_fmt_e'($urandom % 4), $urandom % 57,
                    {$urandom, $urandom}, 1'($urandom % 2));
        end
        for (int b = 0; b < 8; b++) begin
            run_cmd(op_store, fmt_w, 48 + b, {$urandom, $urandom}, 1'b0);
            run_cmd(op_load, fmt_w, 48 + b, 64'd0, 1'b0);
            run_cmd(op_store, fmt_h, 48 + b, {$urandom, $urandom}, 1'b1);
            run_cmd(op_load, fmt_d, 48 + b, 64'd0, 1'b0);
        end
        repeat (4) @(posedge clk);
        check(n_checked, n_issued, "completed commands");
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: filelist.f
hdl/lsu_op_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_split_decode.sv
hdl/lsu_seq_ctrl.sv
hdl/lsu_addr_gen.sv
hdl/lsu_load_merge.sv
hdl/lsu_store_align.sv
hdl/fp_lsu_top.sv
sim/fp_lsu_assertions.sv
sim/tb_fp_lsu.sv

// File: Bender.yml
package:
  name: fp_lsu

sources:
  - files:
      - hdl/lsu_op_pkg.sv
      - hdl/lsu_bus_pkg.sv
      - hdl/lsu_split_decode.sv
      - hdl/lsu_seq_ctrl.sv
      - hdl/lsu_addr_gen.sv
      - hdl/lsu_load_merge.sv
      - hdl/lsu_store_align.sv
      - hdl/fp_lsu_top.sv
  - target: simulation
    files:
      - sim/fp_lsu_assertions.sv
      - sim/tb_fp_lsu.sv
